// File: compile.f
st_cfg_pkg.sv
st_data_pkg.sv
st_sys_ctrl.sv
st_viking_detect.sv
st_rom_map.sv
st_ram_arbiter.sv
st_audio_mix.sv
st_glue_top.sv
tb_st_glue.sv

// File: Makefile
# Verilator build and run for the glue testbench

VERILATOR ?= verilator
TOP       ?= tb_st_glue
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= TEST PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_st_glue.sv
module tb_st_glue
	import st_cfg_pkg::*;
	import st_data_pkg::*;
();

	logic        clk_32;
	logic        xsint;
	ctrl_word_t  system_ctrl_i;
	bus_cycle_t  bus_cycle_i;
	logic        mhz8_en1_i;
	logic        as_n_i;
	word_addr_t  mbus_a_i;
	logic        rom2_n_i;
	word_addr_t  ram_a_i;
	logic        ras_n_i;
	logic        ram_we_n_i;
	ds_t         ram_ds_i;
	data_word_t  ram_din_i;
	logic        blitter_bgack_n_i;
	logic        mcu_bgack_n_i;
	word_addr_t  blitter_addr_i;
	logic        blitter_read_i;
	logic        blitter_write_i;
	data_word_t  blitter_din_i;
	word_addr_t  viking_addr_i;
	logic        viking_read_i;
	logic        dio_download_i;
	word_addr_t  dio_addr_i;
	data_word_t  dio_din_i;
	logic        dio_data_in_strobe_i;
	ym_sample_t  ym_l_i;
	ym_sample_t  ym_r_i;
	dma_sample_t dma_snd_l_i;
	dma_sample_t dma_snd_r_i;
	word_addr_t  sdram_addr_o;
	logic        sdram_req_o;
	logic        sdram_we_o;
	ds_t         sdram_ds_o;
	data_word_t  sdram_din_o;
	word_addr_t  rom_addr_o;
	logic        viking_active_o;
	mix_sample_t audio_l_o;
	mix_sample_t audio_r_o;

	integer seed;
	integer mismatches;   // wrong values seen
	integer timeouts;     // waits that ran out

	st_glue_top DUT (.*);

	always #5 clk_32 = ~clk_32;   // 10 unit period

	task automatic log_error(input string msg);
		mismatches = mismatches + 1;
		$display("Error at time %0t: %s", $time, msg);
	endtask

	// new control word, then 2 cycles for register and decode
	task automatic write_ctrl_word(input ctrl_word_t w);
		@(posedge clk_32);
		system_ctrl_i <= w;
		repeat (2) @(posedge clk_32);
	endtask

	// top of the ram window in bytes, 0 means no window
	function automatic logic [23:0] window_limit(input int size);
		case (size)
			0:       window_limit = 24'h080000;
			1:       window_limit = 24'h100000;
			2:       window_limit = 24'h200000;
			3:       window_limit = 24'h400000;
			4:       window_limit = 24'h800000;
			5:       window_limit = 24'hE00000;   // below c00000 plus c0..df
			default: window_limit = 24'h000000;
		endcase
	endfunction

	function automatic logic ram_allowed(input int size, input word_addr_t a);
		logic [23:0] byte_a;
		begin
			byte_a      = {a, 1'b0};
			ram_allowed = (a != '0) && (byte_a < window_limit(size));
		end
	endfunction

	// centred levels scaled up, low bits refilled from the top of the raw pattern
	function automatic mix_sample_t expected_mix(input ym_sample_t ym, input dma_sample_t dma);
		int ym_v;    // psg level, 16 steps per lsb plus 4 refill bits
		int dma_v;   // dma level, 64 steps per lsb plus 6 refill bits
		int sum;
		begin
			ym_v  = (int'(ym) - 512) * 16 + ((int'(ym) + 512) % 1024) / 64;
			dma_v = (int'(dma) - 128) * 64 + ((int'(dma) + 128) % 256) / 4;
			sum   = ym_v + dma_v;
			expected_mix = mix_sample_t'(sum);   // 15 bit wrap
		end
	endfunction

	// one ras falling edge, request expected in that cycle only
	task automatic pulse_ras(input int size, input word_addr_t addr);
		logic exp;
		begin
			exp = ram_allowed(size, addr);
			@(posedge clk_32);
			ram_a_i <= addr;
			ras_n_i <= 1'b1;
			@(posedge clk_32);
			ras_n_i <= 1'b0;   // ras_n_d still high here
			@(negedge clk_32);
			if (sdram_req_o !== exp)
				log_error($sformatf("size %0d addr %h request %b, expected %b",
				                    size, {addr, 1'b0}, sdram_req_o, exp));
			@(posedge clk_32);
			ras_n_i <= 1'b1;
			@(negedge clk_32);
			if (sdram_req_o !== 1'b0)
				log_error($sformatf("size %0d addr %h request longer than one cycle",
				                    size, {addr, 1'b0}));
		end
	endtask

	// precycle with 8 MHz enable, then a cpu slot, sampled mid-slot
	task automatic run_precycle();
		@(posedge clk_32);
		bus_cycle_i <= cyc_pre;
		mhz8_en1_i  <= 1'b1;
		@(posedge clk_32);
		bus_cycle_i <= cyc_cpu;
		mhz8_en1_i  <= 1'b0;
		@(negedge clk_32);
	endtask

	// one counted cpu access to the viking buffer
	task automatic viking_access();
		logic [31:0] rnd;
		begin
			rnd = $random(seed);
			@(posedge clk_32);
			mhz8_en1_i <= 1'b1;
			as_n_i     <= 1'b0;
			mbus_a_i   <= {VIKING_LO_PREFIX, rnd[16:0]};
			@(posedge clk_32);
			mhz8_en1_i <= 1'b0;
			as_n_i     <= 1'b1;
		end
	endtask

	task automatic load_tos_image(input word_addr_t addr);
		@(posedge clk_32);
		dio_download_i <= 1'b1;
		dio_addr_i     <= addr;
		@(posedge clk_32);
		dio_download_i <= 1'b0;   // flag taken at this edge
	endtask

	task automatic check_rom(input logic sel_n, input word_addr_t addr, input word_addr_t exp);
		@(posedge clk_32);
		rom2_n_i <= sel_n;
		mbus_a_i <= addr;
		@(negedge clk_32);
		if (rom_addr_o !== exp)
			log_error($sformatf("rom2_n %b cpu %h rom address %h, expected %h",
			                    sel_n, addr, rom_addr_o, exp));
	endtask

	task automatic ram_window_test();
		ctrl_word_t  ctrl;
		word_addr_t  addr;
		logic [31:0] rnd;
		logic [23:0] limit;
		int          size;
		int          i;
		begin
			for (size = 0; size < 7; size++) begin   // code 6 has no window
				ctrl = '0;
				ctrl[CTRL_MEM_LSB +: 3] = size[2:0];
				write_ctrl_word(ctrl);
				limit = window_limit(size);
				pulse_ras(size, '0);
				if (limit != '0) begin
					pulse_ras(size, limit[23:1] - 23'd1);   // last word inside
					pulse_ras(size, limit[23:1]);           // first word outside
				end
				for (i = 0; i < 24; i++) begin
					rnd  = $random(seed);
					addr = rnd[22:0] >> ((size < 4) ? (4 - size) : 0);   // about half inside
					pulse_ras(size, addr);
				end
			end
			write_ctrl_word('0);
		end
	endtask

	task automatic download_write_test();
		logic [31:0] rnd;
		word_addr_t  addr;
		data_word_t  din;
		begin
			rnd  = $random(seed);
			addr = {4'h1, rnd[18:0]};   // plain ram, no tos prefix
			rnd  = $random(seed);
			din  = rnd[15:0];
			@(posedge clk_32);
			bus_cycle_i          <= cyc_idle;
			dio_download_i       <= 1'b1;
			dio_addr_i           <= addr;
			dio_din_i            <= din;
			dio_data_in_strobe_i <= ~dio_data_in_strobe_i;   // new word
			run_precycle();
			if (sdram_req_o !== 1'b1)
				log_error("no download request after strobe toggle");
			if (sdram_addr_o !== addr)
				log_error($sformatf("download address %h, expected %h", sdram_addr_o, addr));
			if (sdram_din_o !== din)
				log_error($sformatf("download data %h, expected %h", sdram_din_o, din));
			if (sdram_we_o !== 1'b1 || sdram_ds_o !== 2'b11)
				log_error($sformatf("download we %b ds %b", sdram_we_o, sdram_ds_o));
			@(negedge clk_32);   // still cpu slot, pulse must be gone
			if (sdram_req_o !== 1'b0)
				log_error("download request wider than one cycle");
			run_precycle();   // strobe unchanged this time
			if (sdram_req_o !== 1'b0)
				log_error("download request without strobe toggle");
			@(posedge clk_32);
			dio_download_i <= 1'b0;
			bus_cycle_i    <= cyc_idle;
		end
	endtask

	task automatic blitter_priority_test();
		logic [31:0] rnd;
		logic [31:0] rnd2;
		int          i;
		begin
			for (i = 0; i < 6; i++) begin
				rnd  = $random(seed);
				rnd2 = $random(seed);
				@(posedge clk_32);
				blitter_bgack_n_i <= 1'b0;
				mcu_bgack_n_i     <= 1'b1;
				blitter_addr_i    <= rnd[22:0];
				blitter_din_i     <= rnd2[15:0];
				blitter_write_i   <= rnd[31];
				blitter_read_i    <= ~rnd[31];
				ram_a_i           <= rnd2[22:0];
				ram_din_i         <= rnd[15:0];
				ram_we_n_i        <= rnd2[31];
				ram_ds_i          <= rnd2[30:29];
				bus_cycle_i       <= cyc_cpu;
				@(negedge clk_32);
				if (sdram_addr_o !== rnd[22:0] || sdram_din_o !== rnd2[15:0])
					log_error($sformatf("blitter slot addr %h data %h", sdram_addr_o, sdram_din_o));
				if (sdram_req_o !== 1'b1 || sdram_we_o !== rnd[31] || sdram_ds_o !== 2'b11)
					log_error($sformatf("blitter slot req %b we %b ds %b",
					                    sdram_req_o, sdram_we_o, sdram_ds_o));
				@(posedge clk_32);
				bus_cycle_i <= cyc_pre;   // mcu owns the precycle
				@(negedge clk_32);
				if (sdram_addr_o !== rnd2[22:0] || sdram_din_o !== rnd[15:0])
					log_error($sformatf("precycle addr %h data %h, mcu path expected",
					                    sdram_addr_o, sdram_din_o));
				if (sdram_we_o !== ~rnd2[31] || sdram_ds_o !== rnd2[30:29] || sdram_req_o !== 1'b0)
					log_error($sformatf("precycle we %b ds %b req %b",
					                    sdram_we_o, sdram_ds_o, sdram_req_o));
			end
			@(posedge clk_32);
			blitter_bgack_n_i <= 1'b1;
			blitter_read_i    <= 1'b0;
			blitter_write_i   <= 1'b0;
			bus_cycle_i       <= cyc_idle;
		end
	endtask

	task automatic tos_remap_test();
		logic [31:0] rnd;
		word_addr_t  addr;
		int          i;
		begin
			rnd = $random(seed);
			load_tos_image({TOS192_PREFIX, rnd[16:0]});   // fc0000 image
			for (i = 0; i < 8; i++) begin
				rnd  = $random(seed);
				addr = rnd[22:0];
				check_rom(1'b0, addr, {4'hF, 2'b11, addr[17:1]});
			end
			rnd = $random(seed);
			load_tos_image({TOS256_PREFIX, rnd[18:0]});   // e00000 image
			for (i = 0; i < 8; i++) begin
				rnd  = $random(seed);
				addr = rnd[22:0];
				check_rom(1'b0, addr, {4'hE, 2'b00, addr[17:1]});
				check_rom(1'b1, addr, addr);   // no rom select, passes through
			end
		end
	endtask

	task automatic viking_detect_test();
		ctrl_word_t  ctrl;
		logic [31:0] rnd;
		int          i;
		int          n;
		begin
			ctrl = '0;
			ctrl[CTRL_VIKING_BIT]        = 1'b1;
			ctrl[CTRL_MEM_LSB +: 3]      = 3'd3;   // 4 MB, viking allowed
			write_ctrl_word(ctrl);
			for (i = 0; i < 254; i++)
				viking_access();
			repeat (2) @(posedge clk_32);
			@(negedge clk_32);
			if (viking_active_o !== 1'b0)
				log_error("viking active after only 254 accesses");
			viking_access();
			n = 0;
			@(negedge clk_32);
			while (viking_active_o !== 1'b1 && n < 2) begin
				@(negedge clk_32);
				n++;
			end
			if (viking_active_o !== 1'b1) begin
				timeouts = timeouts + 1;
				$display("viking_active_o did not rise within 2 cycles of the 255th access");
			end
			rnd = $random(seed);
			@(posedge clk_32);
			bus_cycle_i   <= cyc_video;
			viking_read_i <= 1'b1;
			viking_addr_i <= rnd[22:0];
			@(negedge clk_32);
			if (sdram_addr_o !== rnd[22:0] || sdram_req_o !== 1'b1)
				log_error($sformatf("viking fetch addr %h req %b, expected %h",
				                    sdram_addr_o, sdram_req_o, rnd[22:0]));
			@(posedge clk_32);
			bus_cycle_i   <= cyc_idle;
			viking_read_i <= 1'b0;
			write_ctrl_word(ctrl | (ctrl_word_t'(1) << CTRL_RESET_BIT));
			@(negedge clk_32);
			if (viking_active_o !== 1'b0)
				log_error("core reset did not clear viking active");
			write_ctrl_word('0);
		end
	endtask

	task automatic audio_mix_test();
		logic [31:0] rnd;
		logic [31:0] rnd2;
		ym_sample_t  yl;
		ym_sample_t  yr;
		dma_sample_t dl;
		dma_sample_t dr;
		int          i;
		begin
			for (i = 0; i < 40; i++) begin
				rnd  = $random(seed);
				rnd2 = $random(seed);
				yl   = (i == 0) ? 10'h000 : (i == 1) ? 10'h3FF : rnd[9:0];   // extremes first
				yr   = (i == 0) ? 10'h3FF : (i == 1) ? 10'h000 : rnd[19:10];
				dl   = (i == 0) ? 8'h00 : (i == 1) ? 8'hFF : rnd2[7:0];
				dr   = (i == 0) ? 8'hFF : (i == 1) ? 8'h00 : rnd2[15:8];
				@(posedge clk_32);
				ym_l_i      <= yl;
				ym_r_i      <= yr;
				dma_snd_l_i <= dl;
				dma_snd_r_i <= dr;
				@(posedge clk_32);   // sum registered here
				@(negedge clk_32);
				if (audio_l_o !== expected_mix(yl, dl))
					log_error($sformatf("left mix %h for ym %h dma %h, expected %h",
					                    audio_l_o, yl, dl, expected_mix(yl, dl)));
				if (audio_r_o !== expected_mix(yr, dr))
					log_error($sformatf("right mix %h for ym %h dma %h, expected %h",
					                    audio_r_o, yr, dr, expected_mix(yr, dr)));
			end
		end
	endtask

	initial begin
		seed                 = 32'h2242;
		mismatches           = 0;
		timeouts             = 0;
		clk_32               = 1'b0;
		xsint                = 1'b0;
		system_ctrl_i        = '0;
		bus_cycle_i          = cyc_idle;
		mhz8_en1_i           = 1'b0;
		as_n_i               = 1'b1;
		mbus_a_i             = '0;
		rom2_n_i             = 1'b1;
		ram_a_i              = '0;
		ras_n_i              = 1'b1;
		ram_we_n_i           = 1'b1;
		ram_ds_i             = '0;
		ram_din_i            = '0;
		blitter_bgack_n_i    = 1'b1;
		mcu_bgack_n_i        = 1'b0;
		blitter_addr_i       = '0;
		blitter_read_i       = 1'b0;
		blitter_write_i      = 1'b0;
		blitter_din_i        = '0;
		viking_addr_i        = '0;
		viking_read_i        = 1'b0;
		dio_download_i       = 1'b0;
		dio_addr_i           = '0;
		dio_din_i            = '0;
		dio_data_in_strobe_i = 1'b0;
		ym_l_i               = '0;
		ym_r_i               = '0;
		dma_snd_l_i          = '0;
		dma_snd_r_i          = '0;
		repeat (16) @(posedge clk_32);
		xsint <= 1'b1;
		write_ctrl_word('0);   // core out of reset

		ram_window_test();
		download_write_test();
		blitter_priority_test();
		tos_remap_test();
		viking_detect_test();
		audio_mix_test();

		$display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: st_glue_top.sv
module st_glue_top
	import st_cfg_pkg::*;
	import st_data_pkg::*;
(
	input  logic        clk_32,
	input  logic        xsint,

	input  ctrl_word_t  system_ctrl_i,

	input  bus_cycle_t  bus_cycle_i,
	input  logic        mhz8_en1_i,

	// cpu bus
	input  logic        as_n_i,
	input  word_addr_t  mbus_a_i,
	input  logic        rom2_n_i,

	// mcu ram port
	input  word_addr_t  ram_a_i,
	input  logic        ras_n_i,
	input  logic        ram_we_n_i,
	input  ds_t         ram_ds_i,
	input  data_word_t  ram_din_i,

	// blitter master
	input  logic        blitter_bgack_n_i,
	input  logic        mcu_bgack_n_i,
	input  word_addr_t  blitter_addr_i,
	input  logic        blitter_read_i,
	input  logic        blitter_write_i,
	input  data_word_t  blitter_din_i,

	// viking fetch
	input  word_addr_t  viking_addr_i,
	input  logic        viking_read_i,

	// io controller upload
	input  logic        dio_download_i,
	input  word_addr_t  dio_addr_i,
	input  data_word_t  dio_din_i,
	input  logic        dio_data_in_strobe_i,

	// audio sources
	input  ym_sample_t  ym_l_i,
	input  ym_sample_t  ym_r_i,
	input  dma_sample_t dma_snd_l_i,
	input  dma_sample_t dma_snd_r_i,

	output word_addr_t  sdram_addr_o,
	output logic        sdram_req_o,
	output logic        sdram_we_o,
	output ds_t         sdram_ds_o,
	output data_word_t  sdram_din_o,
	output word_addr_t  rom_addr_o,
	output logic        viking_active_o,
	output mix_sample_t audio_l_o,
	output mix_sample_t audio_r_o
);

	logic      core_reset;
	logic      steroids;
	logic      viking_enable;
	mem_size_t mem_size;

	st_sys_ctrl u_sys_ctrl (
		.clk_32          ( clk_32        ),
		.xsint           ( xsint         ),
		.system_ctrl_i   ( system_ctrl_i ),
		.core_reset_o    ( core_reset    ),
		.ste_o           (               ),  // used by the chipset only
		.steroids_o      ( steroids      ),
		.viking_enable_o ( viking_enable ),
		.mem_size_o      ( mem_size      )
	);

	st_viking_detect u_viking_detect (
		.clk_32          ( clk_32          ),
		.xsint           ( xsint           ),
		.core_reset_i    ( core_reset      ),
		.viking_enable_i ( viking_enable   ),
		.steroids_i      ( steroids        ),
		.mhz8_en1_i      ( mhz8_en1_i      ),
		.as_n_i          ( as_n_i          ),
		.mbus_a_i        ( mbus_a_i        ),
		.viking_active_o ( viking_active_o )  // also steers the arbiter
	);

	st_rom_map u_rom_map (
		.clk_32         ( clk_32         ),
		.xsint          ( xsint          ),
		.dio_download_i ( dio_download_i ),
		.dio_addr_i     ( dio_addr_i     ),
		.rom2_n_i       ( rom2_n_i       ),
		.mbus_a_i       ( mbus_a_i       ),
		.rom_addr_o     ( rom_addr_o     )
	);

	st_ram_arbiter u_ram_arbiter (
		.clk_32               ( clk_32               ),
		.xsint                ( xsint                ),
		.steroids_i           ( steroids             ),
		.viking_enable_i      ( viking_enable        ),
		.mem_size_i           ( mem_size             ),
		.viking_active_i      ( viking_active_o      ),
		.bus_cycle_i          ( bus_cycle_i          ),
		.mhz8_en1_i           ( mhz8_en1_i           ),
		.ram_a_i              ( ram_a_i              ),
		.ras_n_i              ( ras_n_i              ),
		.ram_we_n_i           ( ram_we_n_i           ),
		.ram_ds_i             ( ram_ds_i             ),
		.ram_din_i            ( ram_din_i            ),
		.blitter_bgack_n_i    ( blitter_bgack_n_i    ),
		.mcu_bgack_n_i        ( mcu_bgack_n_i        ),
		.blitter_addr_i       ( blitter_addr_i       ),
		.blitter_read_i       ( blitter_read_i       ),
		.blitter_write_i      ( blitter_write_i      ),
		.blitter_din_i        ( blitter_din_i        ),
		.viking_addr_i        ( viking_addr_i        ),
		.viking_read_i        ( viking_read_i        ),
		.dio_download_i       ( dio_download_i       ),
		.dio_addr_i           ( dio_addr_i           ),
		.dio_din_i            ( dio_din_i            ),
		.dio_data_in_strobe_i ( dio_data_in_strobe_i ),
		.sdram_addr_o         ( sdram_addr_o         ),
		.sdram_req_o          ( sdram_req_o          ),
		.sdram_we_o           ( sdram_we_o           ),
		.sdram_ds_o           ( sdram_ds_o           ),
		.sdram_din_o          ( sdram_din_o          )
	);

	st_audio_mix u_audio_mix (
		.clk_32      ( clk_32      ),
		.xsint       ( xsint       ),
		.ym_l_i      ( ym_l_i      ),
		.ym_r_i      ( ym_r_i      ),
		.dma_snd_l_i ( dma_snd_l_i ),
		.dma_snd_r_i ( dma_snd_r_i ),
		.audio_l_o   ( audio_l_o   ),
		.audio_r_o   ( audio_r_o   )
	);

endmodule

// File: st_audio_mix.sv
module st_audio_mix
	import st_data_pkg::*;
(
	input  logic        clk_32,
	input  logic        xsint,

	input  ym_sample_t  ym_l_i,       // psg left
	input  ym_sample_t  ym_r_i,       // psg right
	input  dma_sample_t dma_snd_l_i,  // ste dma left
	input  dma_sample_t dma_snd_r_i,  // ste dma right

	output mix_sample_t audio_l_o,
	output mix_sample_t audio_r_o
);

	// both sources scaled to 14 bits plus sign, then summed
	// low bits refilled from the top ones so full scale stays full scale
	function automatic mix_sample_t mix(input ym_sample_t ym, input dma_sample_t dma);
		ym_sample_t  ym_s;
		dma_sample_t dma_s;
		begin
			ym_s  = ym - YM_OFFSET;    // now two's complement
			dma_s = dma - DMA_OFFSET;
			mix   = {ym_s[9], ym_s, ym_s[9:6]} + {dma_s[7], dma_s, dma_s[7:2]};
		end
	endfunction

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			audio_l_o <= mix(ym_l_i, dma_snd_l_i);
			audio_r_o <= mix(ym_r_i, dma_snd_r_i);
		end
	end

endmodule

// File: st_ram_arbiter.sv
module st_ram_arbiter
	import st_cfg_pkg::*;
	import st_data_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,

	// machine options
	input  logic       steroids_i,
	input  logic       viking_enable_i,
	input  mem_size_t  mem_size_i,
	input  logic       viking_active_i,

	// bus timing from mcu
	input  bus_cycle_t bus_cycle_i,
	input  logic       mhz8_en1_i,

	// mcu ram port
	input  word_addr_t ram_a_i,
	input  logic       ras_n_i,
	input  logic       ram_we_n_i,
	input  ds_t        ram_ds_i,
	input  data_word_t ram_din_i,

	// blitter bus master
	input  logic       blitter_bgack_n_i,
	input  logic       mcu_bgack_n_i,
	input  word_addr_t blitter_addr_i,
	input  logic       blitter_read_i,
	input  logic       blitter_write_i,
	input  data_word_t blitter_din_i,

	// viking video fetch
	input  word_addr_t viking_addr_i,
	input  logic       viking_read_i,

	// io controller download
	input  logic       dio_download_i,
	input  word_addr_t dio_addr_i,
	input  data_word_t dio_din_i,
	input  logic       dio_data_in_strobe_i,  // toggles once per word

	// sdram controller request port
	output word_addr_t sdram_addr_o,
	output logic       sdram_req_o,
	output logic       sdram_we_o,
	output ds_t        sdram_ds_o,
	output data_word_t sdram_din_o
);

	logic ras_n_d;      // ras one clock back
	logic data_wr;      // download word pending, one clock
	logic dio_strb_d;   // strobe level at last precycle
	logic cpu_cycle;
	logic video_cycle;
	logic blitter_has_bus;
	logic ras_fall;
	logic ram_en;       // mcu address inside configured ram
	logic viking_win;

	assign cpu_cycle   = (bus_cycle_i == cyc_cpu);
	assign video_cycle = (bus_cycle_i == cyc_video);  // shifter slot, viking shares it

	// blitter bypasses the mcu, it owns the bus while mcu has released it
	assign blitter_has_bus = ~blitter_bgack_n_i & mcu_bgack_n_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d    <= 1'b0;   // no edge until ras has been seen high
			data_wr    <= 1'b0;
			dio_strb_d <= 1'b0;
		end else begin
			ras_n_d <= ras_n_i;
			data_wr <= 1'b0;
			// strobe sampled in precycle only, write lands in next cpu slot
			if ((bus_cycle_i == cyc_pre) && mhz8_en1_i) begin
				dio_strb_d <= dio_data_in_strobe_i;
				if (dio_data_in_strobe_i ^ dio_strb_d)
					data_wr <= 1'b1;
			end
		end
	end

	assign ras_fall = ras_n_d & ~ras_n_i;

	// frame buffer counts as ram when the card is on
	assign viking_win = viking_enable_i &
	                    (steroids_i ? (ram_a_i[23:19] == VIKING_HI_PREFIX)
	                                : (ram_a_i[23:18] == VIKING_LO_PREFIX));

	always_comb begin
		case (mem_size_i)
			mem_512k: ram_en = (ram_a_i[23:19] == 5'b00000);
			mem_1m:   ram_en = (ram_a_i[23:20] == 4'b0000);
			mem_2m:   ram_en = (ram_a_i[23:21] == 3'b000);
			mem_4m:   ram_en = (ram_a_i[23:22] == 2'b00);
			mem_8m:   ram_en = ~ram_a_i[23];
			// below c00000 plus c00000..dfffff, io and rom stay above
			mem_14m:  ram_en = ~(ram_a_i[23] & ram_a_i[22]) | ~ram_a_i[21];
			default:  ram_en = 1'b0;   // unused size codes
		endcase
		ram_en = ram_en | viking_win;
	end

	// source select, download first, then blitter, viking, mcu
	always_comb begin
		sdram_addr_o = ram_a_i;
		sdram_req_o  = ras_fall & (|ram_a_i) & ram_en;
		sdram_we_o   = ~ram_we_n_i;
		sdram_ds_o   = ram_ds_i;
		sdram_din_o  = ram_din_i;
		if (cpu_cycle && dio_download_i) begin
			sdram_addr_o = dio_addr_i;
			sdram_req_o  = data_wr;   // one write per strobe toggle
			sdram_we_o   = 1'b1;
			sdram_ds_o   = 2'b11;     // full words only
			sdram_din_o  = dio_din_i;
		end else if (cpu_cycle && blitter_has_bus) begin
			sdram_addr_o = blitter_addr_i;
			sdram_req_o  = blitter_read_i | blitter_write_i;
			sdram_we_o   = blitter_write_i;
			sdram_ds_o   = 2'b11;
			sdram_din_o  = blitter_din_i;
		end else if (video_cycle && viking_read_i && viking_active_i) begin
			sdram_addr_o = viking_addr_i;   // mcu is idle in this slot
			sdram_req_o  = 1'b1;
		end
	end

endmodule

// File: st_rom_map.sv
module st_rom_map
	import st_data_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,

	input  logic       dio_download_i,  // io controller upload running
	input  word_addr_t dio_addr_i,      // upload address

	input  logic       rom2_n_i,        // tos rom select from mcu
	input  word_addr_t mbus_a_i,        // cpu address
	output word_addr_t rom_addr_o       // address to the sdram rom port
);

	logic tos192k;   // last tos image was the 192k one

	// image size is only known from where the io controller puts it
	// fc0000 for 192k tos, e00000 for 256k tos
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;
		end else if (dio_download_i) begin
			if (dio_addr_i[23:18] == TOS192_PREFIX)
				tos192k <= 1'b1;
			else if (dio_addr_i[23:20] == TOS256_PREFIX)
				tos192k <= 1'b0;
		end
	end

	// tos rom window onto the uploaded image
	always_comb begin
		if (!rom2_n_i && !tos192k)
			rom_addr_o = {4'hE, 2'b00, mbus_a_i[17:1]};   // e00000 up
		else if (!rom2_n_i)
			rom_addr_o = {4'hF, 2'b11, mbus_a_i[17:1]};   // fc0000 up
		else
			rom_addr_o = mbus_a_i;                        // cartridge etc
	end

endmodule

// File: st_viking_detect.sv
module st_viking_detect
	import st_data_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,
	input  logic       core_reset_i,     // sync clear from control word
	input  logic       viking_enable_i,
	input  logic       steroids_i,       // selects e80000 window
	input  logic       mhz8_en1_i,       // 8 MHz bus phase
	input  logic       as_n_i,           // cpu address strobe
	input  word_addr_t mbus_a_i,         // cpu address
	output logic       viking_active_o   // video switched to viking
);

	logic [7:0] use_cnt;   // accesses seen so far, saturates
	logic       win_hit;
	logic       cnt_inc;

	// frame buffer window, moved up in steroids mode
	assign win_hit = steroids_i ? (mbus_a_i[23:19] == VIKING_HI_PREFIX)
	                            : (mbus_a_i[23:18] == VIKING_LO_PREFIX);

	assign cnt_inc = mhz8_en1_i & ~as_n_i & viking_enable_i & win_hit;

	// a few probes of the area by other software must not flip the video,
	// only a driver that keeps drawing gets there
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			use_cnt         <= '0;
			viking_active_o <= 1'b0;
		end else if (core_reset_i) begin
			use_cnt         <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (cnt_inc && (use_cnt != 8'hff))
				use_cnt <= use_cnt + 8'd1;   // stop at 255
			viking_active_o <= (use_cnt == 8'hff);
		end
	end

endmodule

// File: st_sys_ctrl.sv
module st_sys_ctrl
	import st_cfg_pkg::*;
(
	input  logic       clk_32,
	input  logic       xsint,          // async power-on reset, low active

	input  ctrl_word_t system_ctrl_i,  // raw word from io controller

	output logic       core_reset_o,
	output logic       ste_o,
	output logic       steroids_o,
	output logic       viking_enable_o,
	output mem_size_t  mem_size_o
);

	ctrl_word_t ctrl_q;   // registered control word
	logic       ste_bit;
	logic       mste_bit;
	logic       vik_bit;
	logic       vik_mem_ok;

	// word comes from another clock domain's shift register,
	// one register stage before anything decodes it
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ctrl_q <= CTRL_RESET_VAL;  // core in reset until first word
		end else begin
			ctrl_q <= system_ctrl_i;
		end
	end

	assign ste_bit  = ctrl_q[CTRL_STE_BIT];
	assign mste_bit = ctrl_q[CTRL_MSTE_BIT];
	assign vik_bit  = ctrl_q[CTRL_VIKING_BIT];

	assign core_reset_o = ctrl_q[CTRL_RESET_BIT];
	assign ste_o        = ste_bit | mste_bit;   // mega ste is an ste as well
	assign steroids_o   = ste_bit & mste_bit;   // both set, ste on steroids

	// ram size field, unused codes pass through as-is
	assign mem_size_o = mem_size_t'(ctrl_q[CTRL_MEM_LSB +: $bits(mem_size_t)]);

	// viking buffer sits at c00000, so ram above 8M collides with it
	// steroids moves the buffer to e80000 and lifts the limit
	assign vik_mem_ok      = (mem_size_o <= VIKING_MEM_MAX);
	assign viking_enable_o = (vik_bit & vik_mem_ok) | steroids_o;

endmodule

// File: st_data_pkg.sv
package st_data_pkg;

	// 68000 word address, a0 is never on the bus
	typedef logic [23:1] word_addr_t;

	// 16 bit bus word
	typedef logic [15:0] data_word_t;

	// data strobes, bit 1 upper byte, bit 0 lower byte
	typedef logic [1:0] ds_t;

	// mcu bus slot, shared by cpu, blitter and video
	typedef enum logic [1:0] {
		cyc_pre   = 2'd0,  // precycle, io controller writes are prepared here
		cyc_cpu   = 2'd1,  // cpu, blitter or download slot
		cyc_video = 2'd2,  // shifter / viking fetch
		cyc_idle  = 2'd3
	} bus_cycle_t;

	// audio samples
	typedef logic [9:0]         ym_sample_t;   // psg output, unsigned, mid at 0x200
	typedef logic [7:0]         dma_sample_t;  // ste dma sound, unsigned, mid at 0x80
	typedef logic signed [14:0] mix_sample_t;  // mixed channel, two's complement

	// address window prefixes, compared against the top address bits
	localparam logic [5:0] VIKING_LO_PREFIX = 6'b110000;  // c00000, normal mode
	localparam logic [4:0] VIKING_HI_PREFIX = 5'b11101;   // e80000, steroids mode
	localparam logic [5:0] TOS192_PREFIX    = 6'b111111;  // fc0000, old 192k tos
	localparam logic [3:0] TOS256_PREFIX    = 4'hE;       // e00000, 256k tos

	// dc offsets of the unsigned sample sources
	localparam ym_sample_t  YM_OFFSET  = 10'h200;
	localparam dma_sample_t DMA_OFFSET = 8'h80;

endpackage

// File: st_cfg_pkg.sv
package st_cfg_pkg;

	// 32 bit system control word as delivered by the io controller
	typedef logic [31:0] ctrl_word_t;

	// ram size field of the control word
	// codes 6 and 7 are unused, no ram window then
	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4,
		mem_14m  = 3'd5
	} mem_size_t;

	// bit positions inside the control word
	localparam int CTRL_RESET_BIT  = 0;   // core reset, high active
	localparam int CTRL_MEM_LSB    = 1;   // ram size field, 3 bits wide
	localparam int CTRL_STE_BIT    = 23;  // ste chipset
	localparam int CTRL_MSTE_BIT   = 24;  // mega ste
	localparam int CTRL_VIKING_BIT = 28;  // viking card

	// word seen before the io controller has sent anything
	// core held in reset, all options off
	localparam ctrl_word_t CTRL_RESET_VAL = ctrl_word_t'(1) << CTRL_RESET_BIT;

	// largest ram size that still leaves room for the viking frame buffer at c00000
	localparam mem_size_t VIKING_MEM_MAX = mem_8m;

endpackage
